/* logic/boot_pkg.sv */
// Boot sequencer shared state encoding, status structs and reset timing constants
package boot_pkg;

  ////////////////////
  // Timing constants
  ////////////////////

  // Width of the minimum MCU reset counter
  localparam int MIN_MCU_RST_CNT_W  = 4;
  // MCU held in update reset for at least this many cycles
  localparam int MIN_MCU_RST_CYCLES = 2 ** MIN_MCU_RST_CNT_W;
  // Hitless update counter width, saturates at all ones
  localparam int HITLESS_CNT_W      = 8;

  ////////////////////
  // Boot FSM states
  ////////////////////

  typedef enum logic [3:0] {
    BOOT_IDLE             = 4'h0,
    BOOT_OTP_FC           = 4'h1,
    BOOT_LCC              = 4'h2,
    BOOT_BREAKPOINT_CHECK = 4'h3,
    BOOT_BREAKPOINT       = 4'h4,
    BOOT_MCU              = 4'h5,
    BOOT_WAIT_CPTRA_GO    = 4'h6,
    BOOT_CPTRA            = 4'h7,
    BOOT_WAIT_MCU_RST_REQ = 4'h8,
    BOOT_RST_MCU          = 4'h9,
    // Illegal encodings fall here
    BOOT_UNKNOWN          = 4'hF
  } boot_fsm_state_e;

  // SoC straps, after synchronization
  typedef struct packed {
    logic brkpoint;
    logic no_rom_config;
  } boot_cfg_t;

  // Why the last MCU reset happened
  typedef struct packed {
    logic fw_boot_upd;
    logic fw_hitless_upd;
    logic reset_once;
  } rst_reason_t;

  // Status word seen by the SoC
  typedef struct packed {
    boot_fsm_state_e          state;
    rst_reason_t              reason;
    logic [HITLESS_CNT_W-1:0] hitless_count;
  } boot_status_t;

endpackage

/* logic/sync_2ff.sv */
// Two-flop synchronizer bringing asynchronous level inputs into the clk domain
`timescale 1ns/1ns

module sync_2ff #(
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             mci_rst_b,
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o
);

  // First stage may go metastable
  logic [WIDTH-1:0] meta_q;

  // Both stages clear to zero in reset
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      meta_q <= '0;
      q_o    <= '0;
    end else begin
      meta_q <= d_i;
      q_o    <= meta_q;
    end
  end

endmodule

/* logic/boot_seqr.sv */
// MCI boot sequencer walking fuse, lifecycle, MCU and Caliptra reset release
`timescale 1ns/1ns

module boot_seqr import boot_pkg::*; (
  input  logic            clk,
  input  logic            mci_rst_b,
  // Synchronized straps
  input  boot_cfg_t       cfg_i,
  // Fuse and lifecycle handshake, done already synchronized
  input  logic            fc_opt_done_i,
  input  logic            lc_done_i,
  output logic            fc_opt_init_o,
  output logic            lc_init_o,
  // Go signals, clk domain
  input  logic            bootfsm_go_i,
  input  logic            caliptra_boot_go_i,
  // Firmware update reset
  input  logic            mcu_rst_req_i,
  input  logic            mcu_sram_fw_lock_i,
  // Reset outputs
  output logic            mcu_rst_b_o,
  output logic            cptra_rst_b_o,
  // Status
  output boot_fsm_state_e boot_fsm_o,
  output rst_reason_t     rst_reason_o
);

  boot_fsm_state_e fsm_q;
  boot_fsm_state_e fsm_d;
  // Last state left, tells initial release from update return
  boot_fsm_state_e fsm_prev_q;

  logic fc_init_q;
  logic fc_init_d;
  logic lc_init_q;
  logic lc_init_d;
  logic mcu_rst_b_q;
  logic mcu_rst_b_d;
  logic cptra_rst_b_q;
  logic cptra_rst_b_d;

  rst_reason_t reason_q;
  rst_reason_t reason_d;

  logic [MIN_MCU_RST_CNT_W-1:0] min_rst_cnt_q;
  logic [MIN_MCU_RST_CNT_W-1:0] min_rst_cnt_d;
  logic                         min_rst_done_q;
  logic                         min_rst_done_d;

  ////////////////////
  // State registers
  ////////////////////

  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      fsm_q          <= BOOT_IDLE;
      fsm_prev_q     <= BOOT_IDLE;
      fc_init_q      <= 1'b0;
      lc_init_q      <= 1'b0;
      mcu_rst_b_q    <= 1'b0;
      cptra_rst_b_q  <= 1'b0;
      reason_q       <= '0;
      min_rst_cnt_q  <= '0;
      min_rst_done_q <= 1'b0;
    end else begin
      fsm_q          <= fsm_d;
      // Only update on a real transition
      if (fsm_d != fsm_q) begin
        fsm_prev_q <= fsm_q;
      end
      fc_init_q      <= fc_init_d;
      lc_init_q      <= lc_init_d;
      mcu_rst_b_q    <= mcu_rst_b_d;
      cptra_rst_b_q  <= cptra_rst_b_d;
      reason_q       <= reason_d;
      min_rst_cnt_q  <= min_rst_cnt_d;
      min_rst_done_q <= min_rst_done_d;
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    fsm_d         = fsm_q;
    fc_init_d     = fc_init_q;
    lc_init_d     = lc_init_q;
    mcu_rst_b_d   = mcu_rst_b_q;
    cptra_rst_b_d = cptra_rst_b_q;
    reason_d      = reason_q;
    case (fsm_q)
      // Entered only through MCI reset, lasts one cycle
      BOOT_IDLE: fsm_d = BOOT_OTP_FC;
      BOOT_OTP_FC: begin
        // Init is a level and never drops
        fc_init_d = 1'b1;
        if (fc_opt_done_i) begin
          fsm_d = BOOT_LCC;
        end
      end
      BOOT_LCC: begin
        lc_init_d = 1'b1;
        if (lc_done_i) begin
          fsm_d = BOOT_BREAKPOINT_CHECK;
        end
      end
      BOOT_BREAKPOINT_CHECK: begin
        if (cfg_i.brkpoint) begin
          fsm_d = BOOT_BREAKPOINT;
        end else if (cfg_i.no_rom_config) begin
          fsm_d = BOOT_WAIT_CPTRA_GO;
        end else begin
          fsm_d = BOOT_MCU;
        end
      end
      BOOT_BREAKPOINT: begin
        // Debugger releases the sequence
        if (bootfsm_go_i) begin
          fsm_d = cfg_i.no_rom_config ? BOOT_WAIT_CPTRA_GO : BOOT_MCU;
        end
      end
      BOOT_MCU: begin
        mcu_rst_b_d = 1'b1;
        // Back from an update reset, Caliptra is already running
        fsm_d = (fsm_prev_q == BOOT_RST_MCU) ? BOOT_WAIT_MCU_RST_REQ : BOOT_WAIT_CPTRA_GO;
      end
      BOOT_WAIT_CPTRA_GO: begin
        if (caliptra_boot_go_i) begin
          fsm_d = BOOT_CPTRA;
        end
      end
      BOOT_CPTRA: begin
        cptra_rst_b_d = 1'b1;
        fsm_d         = BOOT_WAIT_MCU_RST_REQ;
      end
      BOOT_WAIT_MCU_RST_REQ: begin
        if (mcu_rst_req_i) begin
          fsm_d                   = BOOT_RST_MCU;
          // First reset is a boot update, later ones are hitless
          reason_d.fw_boot_upd    = !reason_q.reset_once;
          reason_d.fw_hitless_upd = reason_q.reset_once;
        end
      end
      BOOT_RST_MCU: begin
        mcu_rst_b_d         = 1'b0;
        reason_d.reset_once = 1'b1;
        // Release once hold time is met and new image is locked
        if (min_rst_done_q && mcu_sram_fw_lock_i) begin
          fsm_d = BOOT_MCU;
        end
      end
      default: fsm_d = BOOT_UNKNOWN;
    endcase
  end

  ////////////////////
  // Min reset counter
  ////////////////////

  always_comb begin
    min_rst_cnt_d  = min_rst_cnt_q;
    min_rst_done_d = min_rst_done_q;
    // Restart on entry into update reset
    if ((fsm_d == BOOT_RST_MCU) && (fsm_q != BOOT_RST_MCU)) begin
      min_rst_cnt_d  = '0;
      min_rst_done_d = 1'b0;
    end else if (fsm_q == BOOT_RST_MCU) begin
      if (min_rst_cnt_q != MIN_MCU_RST_CNT_W'(MIN_MCU_RST_CYCLES - 1)) begin
        min_rst_cnt_d = min_rst_cnt_q + MIN_MCU_RST_CNT_W'(1);
      end else begin
        min_rst_done_d = 1'b1;
      end
    end
  end

  assign fc_opt_init_o = fc_init_q;
  assign lc_init_o     = lc_init_q;
  assign mcu_rst_b_o   = mcu_rst_b_q;
  assign cptra_rst_b_o = cptra_rst_b_q;
  assign boot_fsm_o    = fsm_q;
  assign rst_reason_o  = reason_q;

  ////////////////////
  // Assertions
  ////////////////////

  // State stays a legal, known encoding
  a_fsm_known: assert property (@(posedge clk) disable iff (!mci_rst_b)
    !$isunknown(boot_fsm_o) && (boot_fsm_o != BOOT_UNKNOWN));

  // Caliptra is never put back into reset by firmware updates
  a_cptra_stays_up: assert property (@(posedge clk) disable iff (!mci_rst_b)
    cptra_rst_b_o |=> cptra_rst_b_o);

endmodule

/* logic/mcu_rst_req_port.sv */
// Four-phase req/ack port turning firmware MCU reset requests into sequencer pulses
`timescale 1ns/1ns

module mcu_rst_req_port import boot_pkg::*; (
  input  logic            clk,
  input  logic            mci_rst_b,
  // Requester side
  input  logic            fw_rst_req_i,
  output logic            fw_rst_ack_o,
  // Sequencer side
  input  boot_fsm_state_e boot_fsm_i,
  input  logic            mcu_rst_b_i,
  output logic            mcu_rst_req_o
);

  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_PENDING,
    REQ_IN_RST,
    REQ_ACKED
  } req_state_e;

  req_state_e state_q;
  req_state_e state_d;
  // MCU reset has been seen low during this request
  logic       seen_low_q;
  logic       seen_low_d;
  logic       seqr_ready;

  // Sequencer only listens in this state
  assign seqr_ready = (boot_fsm_i == BOOT_WAIT_MCU_RST_REQ);

  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      state_q    <= REQ_IDLE;
      seen_low_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      seen_low_q <= seen_low_d;
    end
  end

  always_comb begin
    state_d    = state_q;
    seen_low_d = seen_low_q;
    case (state_q)
      // New request only once ack is low again
      REQ_IDLE: if (fw_rst_req_i) state_d = REQ_PENDING;
      // Hold pending while the sequencer is still booting
      REQ_PENDING: begin
        if (seqr_ready) begin
          state_d    = REQ_IN_RST;
          seen_low_d = 1'b0;
        end
      end
      REQ_IN_RST: begin
        if (!mcu_rst_b_i) begin
          seen_low_d = 1'b1;
        end else if (seen_low_q) begin
          state_d = REQ_ACKED;
        end
      end
      REQ_ACKED: if (!fw_rst_req_i) state_d = REQ_IDLE;
      default:   state_d = REQ_IDLE;
    endcase
  end

  // Single pulse, state leaves PENDING on the same edge
  assign mcu_rst_req_o = (state_q == REQ_PENDING) && seqr_ready;
  assign fw_rst_ack_o  = (state_q == REQ_ACKED);

  a_req_one_cycle: assert property (@(posedge clk) disable iff (!mci_rst_b)
    mcu_rst_req_o |=> !mcu_rst_req_o);

  // Requester must hold req until the update completes
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!mci_rst_b)
    $rose(fw_rst_ack_o) |-> fw_rst_req_i);

endmodule

/* logic/rst_reason_log.sv */
// Reset reason tracking with a saturating count of hitless MCU updates
`timescale 1ns/1ns

module rst_reason_log import boot_pkg::*; (
  input  logic                     clk,
  input  logic                     mci_rst_b,
  input  rst_reason_t              rst_reason_i,
  input  boot_fsm_state_e          boot_fsm_i,
  output logic [HITLESS_CNT_W-1:0] hitless_count_o
);

  // Previous cycle state, for entry detection
  boot_fsm_state_e          fsm_prev_q;
  logic [HITLESS_CNT_W-1:0] hitless_cnt_q;
  logic                     rst_entry;
  logic                     cnt_sat;
  logic                     cnt_inc;

  ////////////////////
  // Entry detect
  ////////////////////

  // First cycle of an update reset
  assign rst_entry = (boot_fsm_i == BOOT_RST_MCU) && (fsm_prev_q != BOOT_RST_MCU);

  // Reason flags are updated on the same edge as the state
  assign cnt_sat = &hitless_cnt_q;
  assign cnt_inc = rst_entry && rst_reason_i.fw_hitless_upd && !cnt_sat;

  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      fsm_prev_q <= BOOT_IDLE;
    end else begin
      fsm_prev_q <= boot_fsm_i;
    end
  end

  ////////////////////
  // Hitless counter
  ////////////////////

  // Holds at all ones once full
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      hitless_cnt_q <= '0;
    end else if (cnt_inc) begin
      hitless_cnt_q <= hitless_cnt_q + HITLESS_CNT_W'(1);
    end
  end

  assign hitless_count_o = hitless_cnt_q;

endmodule

/* logic/mci_boot_top.sv */
// MCI boot block top joining input synchronizers, sequencer, reset port and reason log
`timescale 1ns/1ns

module mci_boot_top import boot_pkg::*; (
  input  logic         clk,
  input  logic         mci_rst_b,
  // Asynchronous inputs
  input  logic         fc_opt_done_i,
  input  logic         lc_done_i,
  input  boot_cfg_t    cfg_i,
  // Synchronous inputs
  input  logic         bootfsm_go_i,
  input  logic         caliptra_boot_go_i,
  input  logic         mcu_sram_fw_lock_i,
  // Firmware reset handshake
  input  logic         fw_rst_req_i,
  output logic         fw_rst_ack_o,
  // Init and reset outputs
  output logic         fc_opt_init_o,
  output logic         lc_init_o,
  output logic         mcu_rst_b_o,
  output logic         cptra_rst_b_o,
  output boot_status_t status_o
);

  logic                     fc_done_sync;
  logic                     lc_done_sync;
  boot_cfg_t                cfg_sync;
  boot_fsm_state_e          boot_fsm;
  rst_reason_t              rst_reason;
  logic                     mcu_rst_req;
  logic [HITLESS_CNT_W-1:0] hitless_count;

  ////////////////////
  // Synchronizers
  ////////////////////

  sync_2ff #(.WIDTH(1)) u_sync_fc_done (
    .clk       (clk),
    .mci_rst_b (mci_rst_b),
    .d_i       (fc_opt_done_i),
    .q_o       (fc_done_sync)
  );

  sync_2ff #(.WIDTH(1)) u_sync_lc_done (
    .clk       (clk),
    .mci_rst_b (mci_rst_b),
    .d_i       (lc_done_i),
    .q_o       (lc_done_sync)
  );

  // Strap pair kept together as one bus
  sync_2ff #(.WIDTH($bits(boot_cfg_t))) u_sync_cfg (
    .clk       (clk),
    .mci_rst_b (mci_rst_b),
    .d_i       (cfg_i),
    .q_o       (cfg_sync)
  );

  ////////////////////
  // Sequencer
  ////////////////////

  boot_seqr u_boot_seqr (
    .clk                (clk),
    .mci_rst_b          (mci_rst_b),
    .cfg_i              (cfg_sync),
    .fc_opt_done_i      (fc_done_sync),
    .lc_done_i          (lc_done_sync),
    .fc_opt_init_o      (fc_opt_init_o),
    .lc_init_o          (lc_init_o),
    .bootfsm_go_i       (bootfsm_go_i),
    .caliptra_boot_go_i (caliptra_boot_go_i),
    .mcu_rst_req_i      (mcu_rst_req),
    .mcu_sram_fw_lock_i (mcu_sram_fw_lock_i),
    .mcu_rst_b_o        (mcu_rst_b_o),
    .cptra_rst_b_o      (cptra_rst_b_o),
    .boot_fsm_o         (boot_fsm),
    .rst_reason_o       (rst_reason)
  );

  // Port watches the MCU reset it causes
  mcu_rst_req_port u_mcu_rst_req_port (
    .clk           (clk),
    .mci_rst_b     (mci_rst_b),
    .fw_rst_req_i  (fw_rst_req_i),
    .fw_rst_ack_o  (fw_rst_ack_o),
    .boot_fsm_i    (boot_fsm),
    .mcu_rst_b_i   (mcu_rst_b_o),
    .mcu_rst_req_o (mcu_rst_req)
  );

  rst_reason_log u_rst_reason_log (
    .clk             (clk),
    .mci_rst_b       (mci_rst_b),
    .rst_reason_i    (rst_reason),
    .boot_fsm_i      (boot_fsm),
    .hitless_count_o (hitless_count)
  );

  assign status_o = '{state: boot_fsm, reason: rst_reason, hitless_count: hitless_count};

endmodule

/* bench/boot_tb.sv */
// Table-driven testbench for the MCI boot block covering boot order, breakpoint and MCU updates
`timescale 1ns/1ns

module boot_tb import boot_pkg::*; ();

  localparam int WAIT_LIMIT     = 300;
  // Update reset must hold the MCU down at least this long
  localparam int MIN_LOW_CYCLES = 16;
  localparam int NUM_ROWS       = 6;

  // Which DUT output a wait or idle check looks at
  typedef enum int {
    P_FC_INIT,
    P_LC_INIT,
    P_MCU_UP,
    P_CPTRA_UP,
    P_ANY_RST,
    P_ACK,
    P_IN_UPD_RST
  } probe_e;

  // One boot scenario
  typedef struct packed {
    logic       brkpoint;
    logic       no_rom_config;
    logic [1:0] num_upd;
    logic [7:0] lock_delay;
  } row_t;

  logic         clk;
  logic         mci_rst_b;
  logic         fc_opt_done_i;
  logic         lc_done_i;
  boot_cfg_t    cfg_i;
  logic         bootfsm_go_i;
  logic         caliptra_boot_go_i;
  logic         mcu_sram_fw_lock_i;
  logic         fw_rst_req_i;
  logic         fw_rst_ack_o;
  logic         fc_opt_init_o;
  logic         lc_init_o;
  logic         mcu_rst_b_o;
  logic         cptra_rst_b_o;
  boot_status_t status_o;

  row_t        rows [NUM_ROWS];
  int unsigned seed_val;

  mci_boot_top u_mci_boot_top (
    .clk                (clk),
    .mci_rst_b          (mci_rst_b),
    .fc_opt_done_i      (fc_opt_done_i),
    .lc_done_i          (lc_done_i),
    .cfg_i              (cfg_i),
    .bootfsm_go_i       (bootfsm_go_i),
    .caliptra_boot_go_i (caliptra_boot_go_i),
    .mcu_sram_fw_lock_i (mcu_sram_fw_lock_i),
    .fw_rst_req_i       (fw_rst_req_i),
    .fw_rst_ack_o       (fw_rst_ack_o),
    .fc_opt_init_o      (fc_opt_init_o),
    .lc_init_o          (lc_init_o),
    .mcu_rst_b_o        (mcu_rst_b_o),
    .cptra_rst_b_o      (cptra_rst_b_o),
    .status_o           (status_o)
  );

  // 8 ns period
  always #4 clk = ~clk;

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t ns: %s, got %0h expected %0h",
                         $time, what, got, exp));
    end
  endtask

  function automatic logic probe(input probe_e sel);
    case (sel)
      P_FC_INIT:    probe = fc_opt_init_o;
      P_LC_INIT:    probe = lc_init_o;
      P_MCU_UP:     probe = mcu_rst_b_o;
      P_CPTRA_UP:   probe = cptra_rst_b_o;
      P_ANY_RST:    probe = mcu_rst_b_o | cptra_rst_b_o;
      P_ACK:        probe = fw_rst_ack_o;
      P_IN_UPD_RST: probe = (status_o.state == BOOT_RST_MCU);
      default:      probe = 1'bx;
    endcase
  endfunction

  // Sampled on the falling edge, away from DUT updates
  task automatic wait_for(input probe_e sel, input logic val, input string what);
    int cyc;
    cyc = 0;
    @(negedge clk);
    while (probe(sel) !== val) begin
      cyc++;
      if (cyc > WAIT_LIMIT) begin
        fail_run($sformatf("Timed out at %0t ns waiting for %s", $time, what));
      end
      @(negedge clk);
    end
  endtask

  // Output must stay low for n cycles
  task automatic idle_check(input int n, input probe_e sel, input string what);
    repeat (n) begin
      @(negedge clk);
      check(probe(sel), 1'b0, what);
    end
  endtask

  task automatic check_quiet(input string what);
    check(mcu_rst_b_o, 1'b0, {"MCU reset ", what});
    check(cptra_rst_b_o, 1'b0, {"Caliptra reset ", what});
    check(fc_opt_init_o, 1'b0, {"fuse init ", what});
    check(lc_init_o, 1'b0, {"lifecycle init ", what});
    check(fw_rst_ack_o, 1'b0, {"ack ", what});
    check(status_o.reason, 3'b000, {"reason flags ", what});
    check(status_o.hitless_count, 0, {"hitless count ", what});
  endtask

  ////////////////////
  // Scenario steps
  ////////////////////

  task automatic reset_dut(input row_t row);
    @(posedge clk);
    mci_rst_b          <= 1'b0;
    fc_opt_done_i      <= 1'b0;
    lc_done_i          <= 1'b0;
    bootfsm_go_i       <= 1'b0;
    caliptra_boot_go_i <= 1'b0;
    mcu_sram_fw_lock_i <= 1'b0;
    fw_rst_req_i       <= 1'b0;
    // Straps stay put for the whole row
    cfg_i              <= {row.brkpoint, row.no_rom_config};
    repeat (4) begin
      @(negedge clk);
      check_quiet("during reset");
    end
    @(posedge clk);
    mci_rst_b <= 1'b1;
    @(negedge clk);
    check_quiet("right after reset");
    check(status_o.state, BOOT_IDLE, "state right after reset");
  endtask

  task automatic run_boot(input row_t row);
    int delay;
    // Fuse controller comes first
    wait_for(P_FC_INIT, 1'b1, "fuse controller init");
    check(lc_init_o, 1'b0, "lifecycle init together with fuse init");
    delay = $urandom % 21;
    idle_check(delay, P_LC_INIT, "lifecycle init before fuse done");
    @(posedge clk);
    fc_opt_done_i <= 1'b1;
    wait_for(P_LC_INIT, 1'b1, "lifecycle controller init");
    delay = $urandom % 21;
    idle_check(delay, P_ANY_RST, "reset released before lifecycle done");
    @(posedge clk);
    lc_done_i <= 1'b1;
    // Debug breakpoint holds both cores
    if (row.brkpoint) begin
      idle_check(30, P_ANY_RST, "reset released at breakpoint");
      @(posedge clk);
      bootfsm_go_i <= 1'b1;
    end
    if (!row.no_rom_config) begin
      wait_for(P_MCU_UP, 1'b1, "MCU reset release");
      check(cptra_rst_b_o, 1'b0, "Caliptra released before MCU");
      idle_check(8, P_CPTRA_UP, "Caliptra released without boot go");
      @(posedge clk);
      caliptra_boot_go_i <= 1'b1;
      wait_for(P_CPTRA_UP, 1'b1, "Caliptra reset release");
    end else begin
      idle_check(8, P_ANY_RST, "reset released without boot go");
      @(posedge clk);
      caliptra_boot_go_i <= 1'b1;
      wait_for(P_CPTRA_UP, 1'b1, "Caliptra reset release");
      // MCU waits for the first update request
      idle_check(20, P_MCU_UP, "MCU released with no update request");
    end
  endtask

  task automatic run_update(input row_t row, input int k);
    int          cyc;
    int          low_cnt;
    logic        lock_on;
    logic        released;
    rst_reason_t exp_reason;
    @(posedge clk);
    fw_rst_req_i <= 1'b1;
    wait_for(P_IN_UPD_RST, 1'b1, "update reset entry");
    cyc      = 0;
    low_cnt  = 0;
    lock_on  = 1'b0;
    released = 1'b0;
    while (!released) begin
      // Lock comes a set number of cycles into the reset
      if (cyc == row.lock_delay) begin
        @(posedge clk);
        mcu_sram_fw_lock_i <= 1'b1;
        lock_on = 1'b1;
      end
      @(negedge clk);
      cyc++;
      check(cptra_rst_b_o, 1'b1, "Caliptra stays up during update");
      if (mcu_rst_b_o === 1'b0) begin
        low_cnt++;
        // No ack while the MCU is still held in reset
        check(fw_rst_ack_o, 1'b0, "ack before MCU release");
      end else if (low_cnt > 0) begin
        released = 1'b1;
      end
      if (cyc > WAIT_LIMIT) begin
        fail_run($sformatf("Timed out at %0t ns waiting for MCU release after update", $time));
      end
    end
    check(lock_on, 1'b1, "MCU released before firmware lock");
    check(low_cnt >= MIN_LOW_CYCLES, 1'b1, "MCU update reset shorter than minimum");
    // First reset is a boot update, the rest hitless
    exp_reason.fw_boot_upd    = (k == 0);
    exp_reason.fw_hitless_upd = (k != 0);
    exp_reason.reset_once     = 1'b1;
    check(status_o.reason, exp_reason, "reset reason flags");
    check(status_o.hitless_count, k, "hitless update count");
    wait_for(P_ACK, 1'b1, "ack after MCU release");
    check(mcu_rst_b_o, 1'b1, "MCU up when ack rises");
    @(posedge clk);
    fw_rst_req_i       <= 1'b0;
    mcu_sram_fw_lock_i <= 1'b0;
    wait_for(P_ACK, 1'b0, "ack to drop after req");
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int r;
    int k;
    clk                = 1'b0;
    mci_rst_b          = 1'b0;
    fc_opt_done_i      = 1'b0;
    lc_done_i          = 1'b0;
    cfg_i              = '0;
    bootfsm_go_i       = 1'b0;
    caliptra_boot_go_i = 1'b0;
    mcu_sram_fw_lock_i = 1'b0;
    fw_rst_req_i       = 1'b0;
    seed_val           = $urandom(57);
    // Breakpoint strap, no ROM config strap, update count, lock delay
    rows[0] = {1'b0, 1'b0, 2'd3, 8'd20};
    rows[1] = {1'b1, 1'b0, 2'd2, 8'd5};
    rows[2] = {1'b0, 1'b1, 2'd2, 8'd0};
    rows[3] = {1'b1, 1'b1, 2'd1, 8'd30};
    rows[4] = {1'b0, 1'b0, 2'd0, 8'd10};
    rows[5] = {1'b0, 1'b1, 2'd0, 8'd3};
    for (r = 0; r < NUM_ROWS; r++) begin
      reset_dut(rows[r]);
      run_boot(rows[r]);
      for (k = 0; k < rows[r].num_upd; k++) begin
        run_update(rows[r], k);
      end
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* files.f */
logic/boot_pkg.sv
logic/sync_2ff.sv
logic/boot_seqr.sv
logic/mcu_rst_req_port.sv
logic/rst_reason_log.sv
logic/mci_boot_top.sv
bench/boot_tb.sv
